// ==== Bender.yml ====
package:
  name: vec_expand

dependencies: {}

sources:
  # RTL in compile order
  - files:
      - logic/vecExpandPkg.sv
      - logic/expandBus.sv
      - logic/vecLaneExpand.sv
      - logic/vecExpand.sv
      - logic/uopDrain.sv
      - logic/vecExpandTop.sv
  # Testbench
  - target: test
    include_dirs:
      - test
    files:
      - test/vecExpandTb.sv

// ==== flist.f ====
+incdir+test
logic/vecExpandPkg.sv
logic/expandBus.sv
logic/vecLaneExpand.sv
logic/vecExpand.sv
logic/uopDrain.sv
logic/vecExpandTop.sv
test/vecExpandTb.sv

// ==== logic/expandBus.sv ====
`timescale 1ns/1ps

// Carries one fully expanded fetch group from the expander to the drain.
// Everything here is meaningful only in the cycle that load is high
interface expandBus;
	import vecExpandPkg::*;

	// ======================================================================
	// Buffer contents
	// ======================================================================

	// Lane k owns slots 8k to 8k+7, element e of that lane sits at 8k+e
	slot_t [SLOTS-1:0] slots;
	// One bit per slot, set where the slot holds a micro-op
	logic [SLOTS-1:0] mask;

	// ======================================================================
	// Control
	// ======================================================================

	// Single-cycle strobe, the consumer takes a copy in this cycle
	logic load;
	// Number of set bits in mask, precomputed by the expander
	logic [CNT_W-1:0] count;

	// The expander writes the whole bundle
	modport producer (
		output slots,
		output mask,
		output load,
		output count
	);

	// The drain only reads it
	modport consumer (
		input slots,
		input mask,
		input load,
		input count
	);

endinterface

// ==== logic/uopDrain.sv ====
`timescale 1ns/1ps

// Holds one expanded group and emits its micro-ops one per cycle,
// lowest slot first
module uopDrain (
	input  logic clk,
	input  logic rst,
	expandBus.consumer bus,
	output logic uopValid,
	output logic uopLast,
	output logic idle,
	output vecExpandPkg::slot_t uopSlot
);
	import vecExpandPkg::*;

	// Copy of the group being drained
	slot_t [SLOTS-1:0] heldSlots;
	// Slots still waiting to be emitted
	logic [SLOTS-1:0] heldMask;
	// Micro-ops left including the one shown this cycle
	logic [CNT_W-1:0] remaining;
	logic [SLOT_IDX_W-1:0] pickIdx;

	// ======================================================================
	// Capture
	// ======================================================================

	// Payload of the group, taken in the load cycle
	always_ff @(posedge clk) begin
		if (bus.load) begin
			heldSlots <= bus.slots;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			heldMask <= '0;
			remaining <= '0;
		end else if (bus.load) begin
			heldMask <= bus.mask;
			remaining <= bus.count;
		end else if (uopValid) begin
			// Subtracting one and masking drops exactly the lowest set bit
			heldMask <= heldMask & (heldMask - 1'b1);
			remaining <= remaining - 1'b1;
		end
	end

	// ======================================================================
	// Priority pick and outputs
	// ======================================================================

	// Scan from the top so the lowest set bit wins
	always_comb begin
		pickIdx = '0;
		for (int i = SLOTS - 1; i >= 0; i--) begin
			if (heldMask[i]) begin
				pickIdx = SLOT_IDX_W'(i);
			end
		end
	end

	// Anything left in the mask goes out this cycle
	assign uopValid = |heldMask;
	assign uopSlot = heldSlots[pickIdx];
	assign uopLast = uopValid && (remaining == CNT_W'(1));

	// Busy from the load cycle until the mask runs empty
	assign idle = !bus.load && !uopValid;

	// ======================================================================
	// Checks
	// ======================================================================

	// A new group must not arrive while the previous one is still going out
	noLoadWhileBusy: assert property (@(posedge clk) disable iff (rst)
		bus.load |-> !uopValid)
		else $error("load while %0d micro-ops still pending", remaining);

	// The count taken from the expander must track the mask as it drains
	remainingTracksMask: assert property (@(posedge clk) disable iff (rst)
		uopValid |-> remaining == CNT_W'($countones(heldMask)))
		else $error("remaining %0d out of step with mask %h", remaining, heldMask);

endmodule

// ==== logic/vecExpand.sv ====
`timescale 1ns/1ps

// Expands a whole fetch group and registers it into the 32-slot buffer
module vecExpand (
	input  logic clk,
	input  logic rst,
	input  logic en,
	input  vecExpandPkg::vecLen_t vl,
	input  vecExpandPkg::mcAddr_t mip,
	input  vecExpandPkg::pcAddr_t [vecExpandPkg::LANES-1:0] pcs,
	input  vecExpandPkg::instr_t [vecExpandPkg::LANES-1:0] insns,
	expandBus.producer bus
);
	import vecExpandPkg::*;

	// Combinational view of the group before it is registered
	slot_t [SLOTS-1:0] nextSlots;
	logic [SLOTS-1:0] nextMask;
	vecLen_t laneCount [LANES];
	logic [CNT_W-1:0] nextCount;

	// ======================================================================
	// Lane expanders
	// ======================================================================

	// Lane k fills the slot range starting at k*MAX_VL
	for (genvar k = 0; k < LANES; k++) begin : gLane
		vecLaneExpand laneExp (
			.lane (LANE_W'(k)),
			.ins  (insns[k]),
			.pc   (pcs[k]),
			.mip  (mip),
			.vl   (vl),
			.slots(nextSlots[k*MAX_VL +: MAX_VL]),
			.mask (nextMask[k*MAX_VL +: MAX_VL]),
			.count(laneCount[k])
		);
	end

	// Total micro-ops in the group, the drain uses it to find the last one
	always_comb begin
		nextCount = '0;
		for (int k = 0; k < LANES; k++) begin
			nextCount += CNT_W'(laneCount[k]);
		end
	end

	// ======================================================================
	// Buffer register and load strobe
	// ======================================================================

	// The buffer only changes on en and otherwise keeps the last group
	always_ff @(posedge clk) begin
		if (rst) begin
			bus.slots <= {SLOTS{NOP_SLOT}};
			bus.mask <= '0;
			bus.count <= '0;
			bus.load <= 1'b0;
		end else begin
			bus.load <= en;
			if (en) begin
				bus.slots <= nextSlots;
				bus.mask <= nextMask;
				bus.count <= nextCount;
			end
		end
	end

	// ======================================================================
	// Checks
	// ======================================================================

	// Two groups in a row would mean en was raised while the drain was busy
	loadSingle: assert property (@(posedge clk) disable iff (rst)
		bus.load |=> !bus.load)
		else $error("load strobe high in consecutive cycles");

	// Summed lane counts must agree with the mask the lanes produced
	countMatchesMask: assert property (@(posedge clk) disable iff (rst)
		bus.count == CNT_W'($countones(bus.mask)))
		else $error("count %0d does not match mask %h", bus.count, bus.mask);

endmodule

// ==== logic/vecExpandPkg.sv ====
package vecExpandPkg;

	// ======================================================================
	// Sizes of the fetch group and the expansion buffer
	// ======================================================================

	// Instructions delivered per fetch strobe
	localparam int LANES = 4;
	// Maximum vector length, also the number of buffer slots per lane
	localparam int MAX_VL = 8;
	localparam int SLOTS = LANES * MAX_VL;

	// Field widths
	localparam int LANE_W = $clog2(LANES);
	localparam int ELEM_W = $clog2(MAX_VL);
	localparam int REG_W = 5;
	// An expanded register is the architectural number with the element appended
	localparam int EREG_W = REG_W + ELEM_W;
	localparam int OP_W = 7;
	localparam int SLOT_IDX_W = $clog2(SLOTS);
	// Wide enough to count a completely full buffer
	localparam int CNT_W = $clog2(SLOTS + 1);

	// Vector length of 0 to MAX_VL
	typedef logic [3:0] vecLen_t;
	typedef logic [31:0] pcAddr_t;
	typedef logic [11:0] mcAddr_t;

	// ======================================================================
	// Instruction, micro-op and buffer slot formats
	// ======================================================================

	// Fetched instruction with a per-register vector flag
	typedef struct packed {
		logic [OP_W-1:0] opcode;
		logic vec;
		logic [REG_W-1:0] rt;
		logic [REG_W-1:0] ra;
		logic [REG_W-1:0] rb;
		logic [REG_W-1:0] rc;
		logic rtVec;
		logic raVec;
		logic rbVec;
		logic rcVec;
	} instr_t;

	// One expanded micro-op as handed to rename
	typedef struct packed {
		logic [OP_W-1:0] opcode;
		logic [EREG_W-1:0] rt;
		logic [EREG_W-1:0] ra;
		logic [EREG_W-1:0] rb;
		logic [EREG_W-1:0] rc;
		logic [ELEM_W-1:0] element;
		logic vec;
		mcAddr_t mip;
	} uop_t;

	// A buffer slot carries the micro-op together with its program counter
	typedef struct packed {
		uop_t uop;
		pcAddr_t pc;
	} slot_t;

	// Slot contents out of reset, a nop pointing at the idle microcode entry
	localparam slot_t NOP_SLOT = '{
		uop: '{opcode: '0, rt: '0, ra: '0, rb: '0, rc: '0,
			element: '0, vec: 1'b0, mip: 12'h1A0},
		pc: '0
	};

endpackage

// ==== logic/vecExpandTop.sv ====
`timescale 1ns/1ps

// Vector expansion stage with plain ports on the fetch and rename sides
module vecExpandTop (
	input  logic clk,
	input  logic rst,
	input  logic en,
	input  vecExpandPkg::vecLen_t vl,
	input  vecExpandPkg::mcAddr_t mip,
	input  vecExpandPkg::pcAddr_t pc0,
	input  vecExpandPkg::pcAddr_t pc1,
	input  vecExpandPkg::pcAddr_t pc2,
	input  vecExpandPkg::pcAddr_t pc3,
	input  vecExpandPkg::instr_t ins0,
	input  vecExpandPkg::instr_t ins1,
	input  vecExpandPkg::instr_t ins2,
	input  vecExpandPkg::instr_t ins3,
	output logic idle,
	output logic uopValid,
	output logic uopLast,
	output vecExpandPkg::pcAddr_t uopPc,
	output vecExpandPkg::mcAddr_t uopMip,
	output logic [vecExpandPkg::OP_W-1:0] uopOp,
	output logic [vecExpandPkg::EREG_W-1:0] uopRt,
	output logic [vecExpandPkg::EREG_W-1:0] uopRa,
	output logic [vecExpandPkg::EREG_W-1:0] uopRb,
	output logic [vecExpandPkg::EREG_W-1:0] uopRc,
	output logic [vecExpandPkg::ELEM_W-1:0] uopElement,
	output logic uopVec
);
	import vecExpandPkg::*;

	slot_t drainSlot;

	// ======================================================================
	// Expander to drain
	// ======================================================================

	expandBus bus ();

	// Lane 0 is the least significant element of the packed lane arrays
	vecExpand expander (
		.clk  (clk),
		.rst  (rst),
		.en   (en),
		.vl   (vl),
		.mip  (mip),
		.pcs  ({pc3, pc2, pc1, pc0}),
		.insns({ins3, ins2, ins1, ins0}),
		.bus  (bus.producer)
	);

	uopDrain drain (
		.clk     (clk),
		.rst     (rst),
		.bus     (bus.consumer),
		.uopValid(uopValid),
		.uopLast (uopLast),
		.idle    (idle),
		.uopSlot (drainSlot)
	);

	// Split the emitted slot into its fields for rename
	assign uopPc = drainSlot.pc;
	assign uopMip = drainSlot.uop.mip;
	assign uopOp = drainSlot.uop.opcode;
	assign uopRt = drainSlot.uop.rt;
	assign uopRa = drainSlot.uop.ra;
	assign uopRb = drainSlot.uop.rb;
	assign uopRc = drainSlot.uop.rc;
	assign uopElement = drainSlot.uop.element;
	assign uopVec = drainSlot.uop.vec;

endmodule

// ==== logic/vecLaneExpand.sv ====
`timescale 1ns/1ps

// Expands the instruction of one fetch lane into its eight buffer slots.
// Purely combinational, the parent registers the result
module vecLaneExpand (
	input  logic [vecExpandPkg::LANE_W-1:0] lane,
	input  vecExpandPkg::instr_t ins,
	input  vecExpandPkg::pcAddr_t pc,
	input  vecExpandPkg::mcAddr_t mip,
	input  vecExpandPkg::vecLen_t vl,
	output vecExpandPkg::slot_t [vecExpandPkg::MAX_VL-1:0] slots,
	output logic [vecExpandPkg::MAX_VL-1:0] mask,
	output vecExpandPkg::vecLen_t count
);
	import vecExpandPkg::*;

	// Renumber a register for one element.
	// A flagged register gets the element index appended, others get zeros
	function automatic logic [EREG_W-1:0] expandReg(
		input logic [REG_W-1:0] r,
		input logic flag,
		input logic [ELEM_W-1:0] elem
	);
		return flag ? {r, elem} : {r, {ELEM_W{1'b0}}};
	endfunction

	// Each lane has its own microcode entry, the lane fills the low bits
	mcAddr_t laneMip;
	assign laneMip = mip | mcAddr_t'(lane);

	// ======================================================================
	// Per-element slot generation
	// ======================================================================

	for (genvar e = 0; e < MAX_VL; e++) begin : gElem
		logic [ELEM_W-1:0] elem;
		slot_t s;

		// A scalar only ever fills the base slot, always as element 0
		assign elem = ins.vec ? ELEM_W'(e) : '0;

		always_comb begin
			s.uop.opcode = ins.opcode;
			s.uop.rt = expandReg(ins.rt, ins.vec && ins.rtVec, elem);
			s.uop.ra = expandReg(ins.ra, ins.vec && ins.raVec, elem);
			s.uop.rb = expandReg(ins.rb, ins.vec && ins.rbVec, elem);
			s.uop.rc = expandReg(ins.rc, ins.vec && ins.rcVec, elem);
			s.uop.element = elem;
			s.uop.vec = ins.vec;
			s.uop.mip = laneMip;
			s.pc = pc;
		end

		assign slots[e] = s;

		// Vector: the first vl elements are live. Scalar: just the base slot
		assign mask[e] = ins.vec ? (e < vl) : (e == 0);
	end

	// Micro-ops this lane contributes to the group
	assign count = ins.vec ? vl : vecLen_t'(1);

	// Vector lengths beyond the buffer depth per lane are not supported
	vlInRange: assert final ($isunknown(vl) || vl <= vecLen_t'(MAX_VL))
		else $error("vector length %0d above %0d", vl, MAX_VL);

endmodule

// ==== test/vecExpandRef.svh ====
`ifndef VEC_EXPAND_REF_SVH
`define VEC_EXPAND_REF_SVH

// One expected micro-op and the last marker it should carry
typedef struct {
	slot_t s;
	logic last;
} expEntry_t;

// Register number times eight plus the element, or plus zero when not renumbered
function automatic logic [EREG_W-1:0] renumber(input logic [REG_W-1:0] r, input logic flag,
	input int e);
	return EREG_W'(int'(r) * MAX_VL + (flag ? e : 0));
endfunction

// Expected micro-ops of a group in drain order.
// Lanes go in order, a vector lane lists elements 0 to vl-1
function automatic int expectGroup(
	input instr_t gIns [LANES],
	input pcAddr_t gPcs [LANES],
	input mcAddr_t gMip,
	input vecLen_t gVl,
	output slot_t list [SLOTS]
);
	int n;
	int elems;
	logic v;
	slot_t s;
	n = 0;
	for (int k = 0; k < LANES; k++) begin
		v = gIns[k].vec;
		elems = v ? int'(gVl) : 1;
		for (int e = 0; e < elems; e++) begin
			s.uop.opcode = gIns[k].opcode;
			s.uop.rt = renumber(gIns[k].rt, v && gIns[k].rtVec, e);
			s.uop.ra = renumber(gIns[k].ra, v && gIns[k].raVec, e);
			s.uop.rb = renumber(gIns[k].rb, v && gIns[k].rbVec, e);
			s.uop.rc = renumber(gIns[k].rc, v && gIns[k].rcVec, e);
			s.uop.element = ELEM_W'(e);
			s.uop.vec = v;
			// Each lane points at its own microcode entry
			s.uop.mip = gMip | mcAddr_t'(k);
			s.pc = gPcs[k];
			list[n] = s;
			n++;
		end
	end
	return n;
endfunction

// ======================================================================
// Compare tasks
// ======================================================================

task automatic checkUop(input string name, input uop_t expUop, input pcAddr_t expPc,
	input uop_t actUop, input pcAddr_t actPc);
	if (actUop !== expUop || actPc !== expPc) begin
		mismatchErrs++;
		$display("** Error %s: expected uop %h pc %h, actual uop %h pc %h",
			name, expUop, expPc, actUop, actPc);
	end
endtask

task automatic checkLast(input string name, input logic expLast, input logic actLast);
	if (actLast !== expLast) begin
		mismatchErrs++;
		$display("** Error %s uopLast: expected %b, actual %b", name, expLast, actLast);
	end
endtask

task automatic checkFlag(input string name, input logic expFlag, input logic actFlag);
	if (actFlag !== expFlag) begin
		mismatchErrs++;
		$display("** Error %s: expected %b, actual %b", name, expFlag, actFlag);
	end
endtask

// Used for cycle counts such as the latency from en to the first micro-op
task automatic checkInt(input string name, input int expVal, input int actVal);
	if (actVal != expVal) begin
		mismatchErrs++;
		$display("** Error %s: expected %0d, actual %0d", name, expVal, actVal);
	end
endtask

`endif

// ==== test/vecExpandTb.sv ====
`timescale 1ns/1ps

module vecExpandTb;
	import vecExpandPkg::*;

	logic clk = 1'b0;
	logic rst;
	logic en;
	vecLen_t vl;
	mcAddr_t mip;
	pcAddr_t pcs [LANES];
	instr_t insns [LANES];
	logic idle;
	logic uopValid;
	logic uopLast;
	pcAddr_t uopPc;
	mcAddr_t uopMip;
	logic [OP_W-1:0] uopOp;
	logic [EREG_W-1:0] uopRt;
	logic [EREG_W-1:0] uopRa;
	logic [EREG_W-1:0] uopRb;
	logic [EREG_W-1:0] uopRc;
	logic [ELEM_W-1:0] uopElement;
	logic uopVec;

	integer seed;
	int mismatchErrs = 0;
	int protoErrs = 0;
	int timeoutErrs = 0;
	bit aborted = 1'b0;
	string testName = "reset";
	// Micro-ops of the group whose en is currently driven
	int groupLen = 0;
	// Test that issued the group now in flight
	string groupName = "";
	bit started = 1'b0;
	bit awaitFirst = 1'b0;
	int sinceEn = 0;
	bit afterEn = 1'b0;
	bit afterLast = 1'b0;

	`include "vecExpandRef.svh"

	// Expected micro-ops in emission order, across all issued groups
	expEntry_t expQ[$];

	vecExpandTop uut (
		.clk(clk), .rst(rst), .en(en), .vl(vl), .mip(mip),
		.pc0(pcs[0]), .pc1(pcs[1]), .pc2(pcs[2]), .pc3(pcs[3]),
		.ins0(insns[0]), .ins1(insns[1]), .ins2(insns[2]), .ins3(insns[3]),
		.idle(idle), .uopValid(uopValid), .uopLast(uopLast), .uopPc(uopPc),
		.uopMip(uopMip), .uopOp(uopOp), .uopRt(uopRt), .uopRa(uopRa), .uopRb(uopRb),
		.uopRc(uopRc), .uopElement(uopElement), .uopVec(uopVec)
	);

	always #4 clk = ~clk;

	// ======================================================================
	// Stimulus helpers, all called at a falling edge
	// ======================================================================

	// Waits for idle within a limit. On a timeout all further stimulus stops
	task automatic waitIdle(input int limit);
		int n;
		n = 0;
		if (aborted) return;
		while (!idle && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (!idle) begin
			timeoutErrs++;
			aborted = 1'b1;
			$display("Timeout in %s: the stage did not return to idle", testName);
		end
	endtask

	// Each lane is vector with the given odds in percent. Flags and registers are random
	task automatic randomGroup(input int vecOdds, output instr_t gIns [LANES],
		output pcAddr_t gPcs [LANES]);
		for (int k = 0; k < LANES; k++) begin
			gIns[k] = instr_t'($random(seed));
			gIns[k].vec = ($unsigned($random(seed)) % 100) < vecOdds;
			gPcs[k] = pcAddr_t'($random(seed));
		end
	endtask

	task automatic issueGroup(input instr_t gIns [LANES], input pcAddr_t gPcs [LANES],
		input mcAddr_t gMip, input vecLen_t gVl);
		slot_t list [SLOTS];
		expEntry_t entry;
		int len;
		waitIdle(200);
		if (aborted) return;
		len = expectGroup(gIns, gPcs, gMip, gVl, list);
		for (int i = 0; i < len; i++) begin
			entry.s = list[i];
			entry.last = (i == len - 1);
			expQ.push_back(entry);
		end
		insns = gIns;
		pcs = gPcs;
		mip = gMip;
		vl = gVl;
		groupLen = len;
		groupName = testName;
		en = 1'b1;
		@(negedge clk);
		en = 1'b0;
	endtask

	// ======================================================================
	// Comparing process
	// ======================================================================

	// Sampled at the rising edge, so it sees the values of the cycle that just ended
	always @(posedge clk) begin : compare
		expEntry_t e;
		uop_t actUop;
		if (!rst) begin
			if (awaitFirst) sinceEn++;
			// Idle drops in the cycle after en and rises again after the last micro-op
			if (afterEn) checkFlag({groupName, " idle after en"}, 1'b0, idle);
			if (afterLast) checkFlag({groupName, " idle after last"}, 1'b1, idle);
			afterLast = uopValid && uopLast;
			if (uopValid) begin
				actUop = '{opcode: uopOp, rt: uopRt, ra: uopRa, rb: uopRb, rc: uopRc,
					element: uopElement, vec: uopVec, mip: uopMip};
				if (awaitFirst) checkInt({groupName, " first micro-op latency"}, 2, sinceEn);
				awaitFirst = 1'b0;
				if (expQ.size() == 0) begin
					protoErrs++;
					$display("Extra micro-op in %s with pc %h", testName, uopPc);
				end else begin
					e = expQ.pop_front();
					checkUop(groupName, e.s.uop, e.s.pc, actUop, uopPc);
					checkLast(groupName, e.last, uopLast);
				end
			end else if (!started) begin
				checkFlag("reset idle", 1'b1, idle);
				checkLast("reset", 1'b0, uopLast);
			end
			afterEn = en;
			// Latency is only defined for groups that produce micro-ops
			if (en) begin
				started = 1'b1;
				awaitFirst = groupLen > 0;
				sinceEn = 0;
			end
		end
	end

	// ======================================================================
	// Test sequence
	// ======================================================================

	initial begin
		instr_t gIns [LANES];
		pcAddr_t gPcs [LANES];
		seed = 32'h12d4_e5e3;
		rst = 1'b1;
		en = 1'b0;
		vl = '0;
		mip = '0;
		for (int k = 0; k < LANES; k++) begin
			pcs[k] = '0;
			insns[k] = '0;
		end
		repeat (3) @(negedge clk);
		rst = 1'b0;
		repeat (4) @(negedge clk);

		testName = "scalar";
		repeat (4) begin
			randomGroup(0, gIns, gPcs);
			issueGroup(gIns, gPcs, mcAddr_t'($random(seed)), vecLen_t'(5));
		end

		// Vector lane moves around while vl sweeps 1 to 8
		testName = "one vector";
		for (int v = 1; v <= MAX_VL; v++) begin
			randomGroup(0, gIns, gPcs);
			gIns[v % LANES].vec = 1'b1;
			issueGroup(gIns, gPcs, mcAddr_t'($random(seed)), vecLen_t'(v));
		end

		testName = "mixed";
		repeat (40) begin
			randomGroup(50, gIns, gPcs);
			issueGroup(gIns, gPcs, mcAddr_t'($random(seed)),
				vecLen_t'($unsigned($random(seed)) % (MAX_VL + 1)));
		end

		testName = "empty";
		repeat (2) begin
			randomGroup(100, gIns, gPcs);
			issueGroup(gIns, gPcs, mcAddr_t'($random(seed)), vecLen_t'(0));
		end
		waitIdle(20);

		testName = "back to back";
		repeat (12) begin
			randomGroup(60, gIns, gPcs);
			issueGroup(gIns, gPcs, mcAddr_t'($random(seed)),
				vecLen_t'($unsigned($random(seed)) % (MAX_VL + 1)));
		end
		waitIdle(200);
		repeat (2) @(negedge clk);

		if (!aborted && expQ.size() != 0) begin
			protoErrs++;
			$display("%0d expected micro-ops never came out", expQ.size());
		end
		$display("Errors: %0d mismatches, %0d missing or extra micro-ops, %0d timeouts",
			mismatchErrs, protoErrs, timeoutErrs);
		if (mismatchErrs + protoErrs + timeoutErrs == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule
